// File: rtl/line_geometry_pkg.sv
package line_geometry_pkg;

	// Visible line, kept short for simulation
	localparam int LINE_WIDTH = 64;
	localparam int COL_BITS   = 6;

	// One tile row is eight 4-bit colours packed in a word
	localparam int TILE_PIXELS   = 8;
	localparam int TILE_BITS     = 32;
	localparam int TILE_NUM_BITS = 4;

	// Derived widths and limits
	localparam int SLOT_BITS = $clog2(TILE_PIXELS);

	localparam logic [COL_BITS-1:0]  LAST_COL  = COL_BITS'(LINE_WIDTH - 1);
	localparam logic [SLOT_BITS-1:0] LAST_SLOT = SLOT_BITS'(TILE_PIXELS - 1);

endpackage

// File: rtl/sprite_pkg.sv
package sprite_pkg;

	// Colour within a tile, zero means see-through
	typedef logic [3:0] color_t;

	// Palette select carried with each sprite
	typedef logic [3:0] palette_t;

	// Larger value wins, it sits nearer the viewer
	typedef logic [1:0] depth_t;

	// Scanout index, palette in the high nibble
	typedef struct packed {
		palette_t palette;
		color_t   color;
	} pixel_index_t;

	// One stored pixel of the line memory
	typedef struct packed {
		pixel_index_t index;
		depth_t       depth;
	} line_entry_t;

	localparam color_t TRANSPARENT = color_t'(0);

endpackage

// File: rtl/line_port_if.sv
`timescale 1ns/1ps

interface line_port_if
	import line_geometry_pkg::*, sprite_pkg::*;
();

	// Column under work, same value for the read and the write
	logic [COL_BITS-1:0] addr;

	// Stored entry, one cycle behind addr
	line_entry_t rd_entry;
	logic        rd_valid;

	// Write back into the bank being built
	logic        wr_en;
	line_entry_t wr_entry;

	modport raster (output addr, output wr_en, output wr_entry,
		input rd_entry, input rd_valid);

	modport store (input addr, input wr_en, input wr_entry,
		output rd_entry, output rd_valid);

endinterface

// File: rtl/sprite_raster.sv
`timescale 1ns/1ps

module sprite_raster
	import line_geometry_pkg::*, sprite_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     load,
	input  logic [COL_BITS-1:0]      sprite_x,
	input  depth_t                   sprite_z,
	input  palette_t                 sprite_palette,
	input  logic [TILE_NUM_BITS-1:0] first_tile,
	input  logic [TILE_NUM_BITS-1:0] last_tile,
	output logic                     line_busy,
	output logic [TILE_NUM_BITS-1:0] current_tile,
	output logic [SLOT_BITS-1:0]     pix_slot,
	output depth_t                   line_z,
	output palette_t                 line_palette,
	input  line_entry_t              merged_entry,
	input  logic                     merge_write,
	line_port_if.raster              port
);

	typedef enum logic [1:0] {
		WAIT,
		START,
		READ,
		WRITE
	} state_t;

	state_t state;
	state_t next_state;

	logic [COL_BITS-1:0]      col;
	logic [TILE_NUM_BITS-1:0] stop_tile;
	logic                     accept;
	logic                     at_edge;
	logic                     tile_done;
	logic                     sprite_done;

	assign line_busy = state != WAIT;
	assign accept    = load && !line_busy;

	// Right edge ends the sprite even mid tile
	assign at_edge     = col == LAST_COL;
	assign tile_done   = pix_slot == LAST_SLOT;
	assign sprite_done = at_edge || (tile_done && current_tile == stop_tile);

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			WAIT:    next_state = accept ? START : WAIT;
			START:   next_state = READ;
			READ:    next_state = WRITE;
			WRITE:   next_state = sprite_done ? WAIT : READ;
			default: next_state = WAIT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= WAIT;
		end else begin
			state <= next_state;
		end
	end

	// Column, pixel slot and tile walk
	always_ff @(posedge clk) begin
		if (!rst) begin
			col          <= '0;
			pix_slot     <= '0;
			current_tile <= '0;
		end else if (accept) begin
			col          <= sprite_x;
			pix_slot     <= '0;
			current_tile <= first_tile;
		end else if (state == WRITE) begin
			col      <= col + 1'b1;
			// Slot wraps to zero on its own after the last pixel
			pix_slot <= pix_slot + 1'b1;
			if (tile_done) begin
				current_tile <= current_tile + 1'b1;
			end
		end
	end

	// Sprite attributes held for the whole walk
	always_ff @(posedge clk) begin
		if (accept) begin
			line_z       <= sprite_z;
			line_palette <= sprite_palette;
			stop_tile    <= last_tile;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Line port
	////////////////////////////////////////////////////////////////////////////

	// Address holds through READ and WRITE of one pixel
	assign port.addr     = col;
	assign port.wr_en    = (state == WRITE) && merge_write;
	assign port.wr_entry = merged_entry;

endmodule

// File: rtl/pixel_merge.sv
`timescale 1ns/1ps

module pixel_merge
	import line_geometry_pkg::*, sprite_pkg::*;
(
	input  logic [TILE_BITS-1:0] tile_data,
	input  logic                 tile_flip,
	input  logic [SLOT_BITS-1:0] pix_slot,
	input  depth_t               line_z,
	input  palette_t             line_palette,
	input  line_entry_t          rd_entry,
	input  logic                 rd_valid,
	output line_entry_t          merged_entry,
	output logic                 merge_write
);

	logic [SLOT_BITS-1:0] nibble;
	color_t               color;
	logic                 opaque;
	logic                 wins;

	// Nibble 0 is the leftmost pixel, mirroring walks from the other end
	assign nibble = tile_flip ? LAST_SLOT - pix_slot : pix_slot;
	assign color  = tile_data[nibble * $bits(color_t) +: $bits(color_t)];

	assign opaque = color != TRANSPARENT;

	// Strictly nearer replaces, a tie keeps what is already there
	assign wins = !rd_valid || (line_z > rd_entry.depth);

	assign merge_write = opaque && wins;

	always_comb begin
		merged_entry               = '0;
		merged_entry.index.palette = line_palette;
		merged_entry.index.color   = color;
		merged_entry.depth         = line_z;
	end

endmodule

// File: rtl/line_store.sv
`timescale 1ns/1ps

module line_store
	import line_geometry_pkg::*, sprite_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                front,
	input  logic [COL_BITS-1:0] x,
	output pixel_index_t        index,
	output logic                enable,
	line_port_if.store          port
);

	// Two banks, front picks the one under construction
	line_entry_t mem [2][LINE_WIDTH];

	logic [LINE_WIDTH-1:0] valid [2];
	logic                  front_q;
	logic                  swap;
	logic                  scan_bank;

	assign swap      = front != front_q;
	assign scan_bank = !front;

	////////////////////////////////////////////////////////////////////////////
	// Entry storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (port.wr_en) begin
			mem[front][port.addr] <= port.wr_entry;
		end
		port.rd_entry <= mem[front][port.addr];
		// Scanout only needs the pixel index, depth stays behind
		index         <= mem[scan_bank][x].index;
	end

	////////////////////////////////////////////////////////////////////////////
	// Valid flags
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			valid[0]      <= '0;
			valid[1]      <= '0;
			front_q       <= 1'b0;
			port.rd_valid <= 1'b0;
			enable        <= 1'b0;
		end else begin
			front_q <= front;
			// Fresh back bank starts empty after every swap
			if (swap) begin
				valid[front] <= '0;
			end
			if (port.wr_en) begin
				valid[front][port.addr] <= 1'b1;
			end
			port.rd_valid <= valid[front][port.addr];
			enable        <= valid[scan_bank][x];
		end
	end

endmodule

// File: rtl/sprite_line_top.sv
`timescale 1ns/1ps

module sprite_line_top
	import line_geometry_pkg::*, sprite_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     load,
	input  logic [COL_BITS-1:0]      sprite_x,
	input  depth_t                   sprite_z,
	input  palette_t                 sprite_palette,
	input  logic [TILE_NUM_BITS-1:0] first_tile,
	input  logic [TILE_NUM_BITS-1:0] last_tile,
	output logic                     line_busy,
	output logic [TILE_NUM_BITS-1:0] current_tile,
	input  logic [TILE_BITS-1:0]     tile_data,
	input  logic                     tile_flip,
	input  logic                     front,
	input  logic [COL_BITS-1:0]      x,
	output pixel_index_t             index,
	output logic                     enable
);

	logic [SLOT_BITS-1:0] pix_slot;
	depth_t               line_z;
	palette_t             line_palette;
	line_entry_t          merged_entry;
	logic                 merge_write;

	line_port_if port_bus ();

	sprite_raster u_raster (
		.clk            (clk),
		.rst            (rst),
		.load           (load),
		.sprite_x       (sprite_x),
		.sprite_z       (sprite_z),
		.sprite_palette (sprite_palette),
		.first_tile     (first_tile),
		.last_tile      (last_tile),
		.line_busy      (line_busy),
		.current_tile   (current_tile),
		.pix_slot       (pix_slot),
		.line_z         (line_z),
		.line_palette   (line_palette),
		.merged_entry   (merged_entry),
		.merge_write    (merge_write),
		.port           (port_bus.raster)
	);

	// Sits between the read data and the write back
	pixel_merge u_merge (
		.tile_data    (tile_data),
		.tile_flip    (tile_flip),
		.pix_slot     (pix_slot),
		.line_z       (line_z),
		.line_palette (line_palette),
		.rd_entry     (port_bus.rd_entry),
		.rd_valid     (port_bus.rd_valid),
		.merged_entry (merged_entry),
		.merge_write  (merge_write)
	);

	line_store u_store (
		.clk    (clk),
		.rst    (rst),
		.front  (front),
		.x      (x),
		.index  (index),
		.enable (enable),
		.port   (port_bus.store)
	);

endmodule

// File: bench/sprite_line_assertions.sv
`timescale 1ns/1ps

module sprite_line_assertions
	import line_geometry_pkg::*;
(
	input logic                clk,
	input logic                rst,
	input logic                front,
	input logic                line_busy,
	input logic [1:0]          state,
	input logic                wr_en,
	input logic [COL_BITS-1:0] addr
);

	// Encodings of READ and WRITE in the rasterizer state register
	localparam logic [1:0] READ_STATE  = 2'd2;
	localparam logic [1:0] WRITE_STATE = 2'd3;

	front_steady: assert property (@(posedge clk) disable iff (!rst)
		line_busy |-> $stable(front))
		else $error("front changed while a sprite was being drawn");

	// Write back lands on the column read just before
	write_in_write_state: assert property (@(posedge clk) disable iff (!rst)
		wr_en |-> state == WRITE_STATE && $past(state) == READ_STATE && $stable(addr))
		else $error("line write outside the WRITE state that follows its read");

	idle_after_reset: assert property (@(posedge clk)
		!rst |=> !line_busy)
		else $error("line_busy high after reset");

	// A wrap back toward column 0 would mean a write past the right edge
	column_on_line: assert property (@(posedge clk) disable iff (!rst)
		line_busy && $past(line_busy) |-> addr >= $past(addr))
		else $error("column wrapped past the right edge of the line");

endmodule

// Top level sees both the rasterizer and the line store
bind sprite_line_top sprite_line_assertions u_assertions (
	.clk       (clk),
	.rst       (rst),
	.front     (front),
	.line_busy (line_busy),
	.state     (u_raster.state),
	.wr_en     (port_bus.wr_en),
	.addr      (port_bus.addr)
);

// File: bench/sprite_line_tb.sv
`timescale 1ns/1ps

module sprite_line_tb
	import line_geometry_pkg::*, sprite_pkg::*;
();

	// Golden records are six words with the kind first
	localparam int REC_WORDS  = 6;
	localparam int MAX_WORDS  = 64 * REC_WORDS;
	localparam int TILE_COUNT = 2 ** TILE_NUM_BITS;

	logic                     clk;
	logic                     rst;
	logic                     load;
	logic [COL_BITS-1:0]      sprite_x;
	depth_t                   sprite_z;
	palette_t                 sprite_palette;
	logic [TILE_NUM_BITS-1:0] first_tile;
	logic [TILE_NUM_BITS-1:0] last_tile;
	logic                     line_busy;
	logic [TILE_NUM_BITS-1:0] current_tile;
	logic [TILE_BITS-1:0]     tile_data;
	logic                     tile_flip;
	logic                     front;
	logic [COL_BITS-1:0]      x;
	pixel_index_t             index;
	logic                     enable;

	logic [31:0]          golden [MAX_WORDS];
	logic [TILE_BITS-1:0] tile_rows [TILE_COUNT];
	logic                 tile_flips [TILE_COUNT];
	int                   cycles = 0;
	int                   limit = 0;

	sprite_line_top DUT (.*);

	// Tile source answers in the same cycle
	assign tile_data = tile_rows[current_tile];
	assign tile_flip = tile_flips[current_tile];

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			fail_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
		end
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("MISMATCH at %0t: %s is %0h, expected %0h",
				$time, what, actual, expected));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic draw_sprite(input int rec);
		sprite_x       = COL_BITS'(golden[rec + 1]);
		sprite_z       = depth_t'(golden[rec + 2]);
		sprite_palette = palette_t'(golden[rec + 3]);
		first_tile     = TILE_NUM_BITS'(golden[rec + 4]);
		last_tile      = TILE_NUM_BITS'(golden[rec + 5]);
		load           = 1'b1;
		next_cycle();
		load = 1'b0;
		compare_value("line_busy after load", 32'(line_busy), 32'd1);
		while (line_busy) begin
			next_cycle();
		end
	endtask

	task automatic swap_banks();
		front = ~front;
		next_cycle();
	endtask

	task automatic scan_column(input int rec);
		x = COL_BITS'(golden[rec + 1]);
		next_cycle();
		compare_value($sformatf("enable at column %0d", x), 32'(enable), golden[rec + 3]);
		// Index means nothing where no pixel was written
		if (golden[rec + 3] != 0) begin
			compare_value($sformatf("index at column %0d", x), 32'(index), golden[rec + 2]);
		end
	endtask

	initial begin
		int rec;
		rst            = 1'b0;
		load           = 1'b0;
		sprite_x       = '0;
		sprite_z       = '0;
		sprite_palette = '0;
		first_tile     = '0;
		last_tile      = '0;
		front          = 1'b0;
		x              = '0;
		tile_rows      = '{default: '0};
		tile_flips     = '{default: 1'b0};
		$readmemh("bench/sprite_line_golden.txt", golden);

		// 17 cycles per tile and 4 per sprite plus 2 per scan then doubled
		for (rec = 0; rec < MAX_WORDS && golden[rec] != 0; rec += REC_WORDS) begin
			if (golden[rec] == 32'd2) begin
				limit += 17 * int'(golden[rec + 5] - golden[rec + 4] + 1) + 4;
			end else if (golden[rec] == 32'd4) begin
				limit += 2;
			end
		end
		limit *= 2;

		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;
		compare_value("current_tile after reset", 32'(current_tile), 32'd0);
		compare_value("enable after reset", 32'(enable), 32'd0);

		for (rec = 0; rec < MAX_WORDS && golden[rec] != 0; rec += REC_WORDS) begin
			case (golden[rec])
				32'd1: begin
					tile_rows[golden[rec + 1][TILE_NUM_BITS-1:0]]  = golden[rec + 3];
					tile_flips[golden[rec + 1][TILE_NUM_BITS-1:0]] = golden[rec + 2][0];
				end
				32'd2: draw_sprite(rec);
				32'd3: swap_banks();
				32'd4: scan_column(rec);
				default: fail_run($sformatf("Unknown record kind %0h in the golden file",
					golden[rec]));
			endcase
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: bench/sprite_line_golden.txt
// kind 1 tile: number flip row    kind 2 sprite: column depth palette first last
// kind 3 swap    kind 4 scan: column index enable (index unchecked at enable 0)    kind 0 end
1 1 0 87654321 0 0
1 2 0 1fedcba9 0 0
1 3 0 05050505 0 0
1 4 0 77777777 0 0
1 5 1 87654321 0 0
2 08 1 3 1 2
3 0 0 0 0 0
4 07 00 0 0 0
4 08 31 1 0 0
4 0f 38 1 0 0
4 10 39 1 0 0
4 17 31 1 0 0
4 18 00 0 0 0
2 14 1 2 4 4
2 18 2 5 3 3
2 1a 2 6 4 4
2 14 0 1 4 4
2 28 1 4 5 5
2 3c 3 7 1 2
3 0 0 0 0 0
4 14 27 1 0 0
4 18 55 1 0 0
4 19 27 1 0 0
4 1a 55 1 0 0
4 1b 67 1 0 0
4 22 00 0 0 0
4 28 48 1 0 0
4 2f 41 1 0 0
4 3f 74 1 0 0
4 00 00 0 0 0
2 04 0 9 4 4
4 14 27 1 0 0
3 0 0 0 0 0
4 04 97 1 0 0
4 0c 00 0 0 0
0 0 0 0 0 0

// File: list.f
rtl/line_geometry_pkg.sv
rtl/sprite_pkg.sv
rtl/line_port_if.sv
rtl/sprite_raster.sv
rtl/pixel_merge.sv
rtl/line_store.sv
rtl/sprite_line_top.sv
bench/sprite_line_assertions.sv
bench/sprite_line_tb.sv

// File: Makefile
VERILATOR = verilator
TOP       = sprite_line_tb
FILELIST  = list.f
FLAGS     = --timing --assert
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
